// File: Makefile
TOP ?= tb_pe_tile_bottom
VERILATOR ?= verilator
OBJ_DIR ?= obj_dir
LOG ?= sim.log
SIM_ARGS ?= +verilator+error+limit+1000
VFLAGS ?= --timing --assert -f sources.f --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_clock.sv
module tb_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period.
	localparam real half_period = 2.0;

	initial begin
		clk = 1'b0;
		forever begin
			#(half_period) clk = ~clk;
		end
	end

endmodule

// File: bench/tb_pe_tile_bottom.sv
module tb_pe_tile_bottom;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] dut_id = 16'h0005;
	localparam int reset_cycles = 8;
	localparam int idle_cycles = 20;
	localparam int stim_cycles = 2000;
	// a fifth of margin over the stimulus length.
	localparam int cycle_limit = stim_cycles + stim_cycles / 5;

	logic clk;
	logic rst;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	logic [15:0] tracks;
	logic [15:0] outs;
	logic in_wire_0_0, in_wire_0_1, in_wire_0_2, in_wire_0_3;
	logic in_wire_1_0, in_wire_1_1, in_wire_1_2, in_wire_1_3;
	logic in_wire_2_0, in_wire_2_1, in_wire_2_2, in_wire_2_3;
	logic in_wire_3_0, in_wire_3_1, in_wire_3_2, in_wire_3_3;
	logic out_wire_0_0, out_wire_0_1, out_wire_0_2, out_wire_0_3;
	logic out_wire_1_0;
	logic out_wire_2_0, out_wire_2_1, out_wire_2_2, out_wire_2_3;
	logic out_wire_3_0, out_wire_3_1, out_wire_3_2, out_wire_3_3;
	int seed = 32'h51bc_eba3;
	int error_count;
	int cycle_count = 0;

	assign {in_wire_3_3, in_wire_3_2, in_wire_3_1, in_wire_3_0,
		in_wire_2_3, in_wire_2_2, in_wire_2_1, in_wire_2_0,
		in_wire_1_3, in_wire_1_2, in_wire_1_1, in_wire_1_0,
		in_wire_0_3, in_wire_0_2, in_wire_0_1, in_wire_0_0} = tracks;

	assign outs = {out_wire_3_3, out_wire_3_2, out_wire_3_1, out_wire_3_0,
		out_wire_2_3, out_wire_2_2, out_wire_2_1, out_wire_2_0,
		3'b000, out_wire_1_0,
		out_wire_0_3, out_wire_0_2, out_wire_0_1, out_wire_0_0};

	tb_clock clock_gen (
		.clk (clk)
	);

	pe_tile_bottom u_dut (.*);

	tile_checker check (
		.clk         (clk),
		.rst         (rst),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.in_wires    (tracks),
		.out_wires   (outs),
		.error_count (error_count)
	);

	// about one cycle in four writes to this tile, another tile or an unused feature.
	task automatic drive_config();
		int roll;
		logic [15:0] id;
		logic [15:0] feature;
		roll = $random(seed);
		config_data = $random(seed);
		if (roll[1:0] != 2'd0) begin
			// tile 0 never matches.
			config_addr = '0;
		end else begin
			if (roll[3:2] == 2'd0) begin
				id = 16'($random(seed));
				if (id == dut_id) begin
					id = ~id;
				end
			end else begin
				id = dut_id;
			end
			if (roll[7:4] == 4'd0) begin
				feature = 16'h0008 + {8'h00, roll[15:8]};
			end else begin
				case (roll[9:8])
					2'd0: feature = tile_pkg::config_sb;
					2'd1: feature = tile_pkg::config_cb0;
					2'd2: feature = tile_pkg::config_cb1;
					default: feature = tile_pkg::config_clb;
				endcase
			end
			config_addr = {feature, id};
		end
	endtask

	task automatic finish_run();
		int assert_errors;
		assert_errors = u_dut.u_props.assert_failures;
		$display("errors: %0d checker, %0d assertion", error_count, assert_errors);
		if (error_count == 0 && assert_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		config_addr = '0;
		config_data = '0;
		tile_id = dut_id;
		tracks = '0;
		// writes during reset must not stick.
		repeat (reset_cycles) begin
			@(posedge clk);
			#1;
			tracks = 16'($random(seed));
			drive_config();
		end
		rst = 1'b0;
		config_addr = '0;
		// reset routing only.
		repeat (idle_cycles) begin
			@(posedge clk);
			#1;
			tracks = 16'($random(seed));
		end
		repeat (stim_cycles) begin
			@(posedge clk);
			#1;
			tracks = 16'($random(seed));
			drive_config();
		end
		repeat (3) @(posedge clk);
		finish_run();
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("errors: %0d checker, %0d assertion, 1 timeout", error_count,
				u_dut.u_props.assert_failures);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

// File: bench/tile_checker.sv
module tile_checker (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] config_addr,
	input  logic [31:0] config_data,
	input  logic [15:0] tile_id,
	input  logic [15:0] in_wires,
	input  logic [15:0] out_wires,
	output int          error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0][1:0] sb_sel_m;
	logic [2:0] cb0_sel_m;
	logic [2:0] cb1_sel_m;
	logic [1:0] op_m;
	logic pe_m;

	// output (s, t) takes the sel-th side other than s, or the compute result.
	function automatic logic route_one(int s, int t, logic [1:0] sel, logic [15:0] ins,
			logic pe);
		int k;
		logic bit_out;
		k = 0;
		bit_out = pe;
		if (sel != tile_pkg::sel_pe) begin
			for (int side = 0; side < 4; side++) begin
				if (side != s) begin
					if (k == int'(sel)) begin
						bit_out = ins[side * tile_pkg::tracks_per_side + t];
					end
					k++;
				end
			end
		end
		return bit_out;
	endfunction

	function automatic logic [15:0] route_all(logic [15:0] ins, logic [15:0][1:0] sel,
			logic pe);
		logic [15:0] result;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < tile_pkg::tracks_per_side; t++) begin
				result[s * 4 + t] = route_one(s, t, sel[s * 4 + t], ins, pe);
			end
		end
		return result;
	endfunction

	function automatic logic apply_op(logic [1:0] op, logic a, logic b);
		logic result;
		case (op)
			tile_pkg::op_and: result = a & b;
			tile_pkg::op_or: result = a | b;
			tile_pkg::op_xor: result = a ^ b;
			default: result = a;
		endcase
		return result;
	endfunction

	// mirror of the configuration and the compute register.
	always @(posedge clk) begin : model
		tile_pkg::config_word_u word;
		logic [15:0] routed;
		logic [7:0] cb0_tracks;
		logic [7:0] cb1_tracks;
		if (rst) begin
			sb_sel_m = '0;
			cb0_sel_m = '0;
			cb1_sel_m = '0;
			op_m = tile_pkg::op_and;
			pe_m = 1'b0;
		end else begin
			word = config_data;
			routed = route_all(in_wires, sb_sel_m, pe_m);
			cb0_tracks = {routed[3:0], in_wires[3:0]};
			cb1_tracks = {routed[7:4], in_wires[7:4]};
			pe_m = apply_op(op_m, cb0_tracks[cb0_sel_m], cb1_tracks[cb1_sel_m]);
			if (config_addr[15:0] == tile_id) begin
				case (config_addr[31:16])
					tile_pkg::config_sb: sb_sel_m = word.sb;
					tile_pkg::config_cb0: cb0_sel_m = word.cb.sel;
					tile_pkg::config_cb1: cb1_sel_m = word.cb.sel;
					tile_pkg::config_clb: op_m = word.clb.op;
					default: ;
				endcase
			end
		end
	end

	task automatic compare_outputs();
		logic [15:0] expected;
		expected = route_all(in_wires, sb_sel_m, pe_m);
		for (int idx = 0; idx < 16; idx++) begin
			// side 1 tracks 1 to 3 stay inside the tile.
			if (idx < 5 || idx > 7) begin
				if (out_wires[idx] !== expected[idx]) begin
					error_count++;
					$display("error: out_wire_%0d_%0d expected 0x%h got 0x%h",
						idx / 4, idx % 4, expected[idx], out_wires[idx]);
				end
			end
		end
	endtask

	// sample 1 ns before each rising edge.
	initial begin
		error_count = 0;
		forever begin
			@(posedge clk);
			#3;
			if (!rst) begin
				compare_outputs();
			end
		end
	end

endmodule

// File: bench/tile_properties.sv
module tile_properties (
	input logic        clk,
	input logic        rst,
	input logic [31:0] config_addr,
	input logic [15:0] tile_id,
	input logic        en_sb,
	input logic        en_cb0,
	input logic        en_cb1,
	input logic        en_clb,
	input logic        pe_output
);

	timeunit 1ns;
	timeprecision 100ps;

	int assert_failures = 0;
	logic [3:0] enables;

	assign enables = {en_sb, en_cb0, en_cb1, en_clb};

	a_enables_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(enables))
	else begin
		assert_failures++;
		$error("more than one decoder enable is high");
	end

	a_foreign_tile: assert property (@(posedge clk) disable iff (rst)
		(config_addr[tile_pkg::tile_field_lsb +: 16] != tile_id) |-> (enables == 4'b0000))
	else begin
		assert_failures++;
		$error("decoder enable high for a write to another tile");
	end

	// compute register cleared once reset drops.
	a_reset_clears_pe: assert property (@(posedge clk) $fell(rst) |-> !pe_output)
	else begin
		assert_failures++;
		$error("compute output not cleared by reset");
	end

endmodule

bind pe_tile_bottom tile_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.config_addr (config_addr),
	.tile_id     (tile_id),
	.en_sb       (en_sb),
	.en_cb0      (en_cb0),
	.en_cb1      (en_cb1),
	.en_clb      (en_clb),
	.pe_output   (pe_output)
);

// File: rtl/clb.sv
module clb (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in0,
	input  logic                   in1,
	input  logic                   config_en,
	input  tile_pkg::config_word_u config_data,
	output logic                   out
);

	logic [tile_pkg::op_width-1:0] op_q;
	logic result;

	// operation register, and after reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= tile_pkg::op_and;
		end else if (config_en) begin
			op_q <= config_data.clb.op;
		end
	end

	always_comb begin
		case (op_q)
			tile_pkg::op_and: begin
				result = in0 & in1;
			end
			tile_pkg::op_or: begin
				result = in0 | in1;
			end
			tile_pkg::op_xor: begin
				result = in0 ^ in1;
			end
			default: begin
				// op_pass forwards in0.
				result = in0;
			end
		endcase
	end

	// result register, also breaks the routing loop.
	always_ff @(posedge clk) begin
		if (rst) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

endmodule

// File: rtl/config_decode.sv
module config_decode (
	input  logic [31:0] config_addr,
	input  logic [15:0] tile_id,
	output logic        en_sb,
	output logic        en_cb0,
	output logic        en_cb1,
	output logic        en_clb
);

	logic [tile_pkg::tile_field_width-1:0] tile_field;
	logic [tile_pkg::feature_field_width-1:0] feature_field;
	logic tile_match;

	// split the address into its two fields.
	assign tile_field = config_addr[tile_pkg::tile_field_lsb +: tile_pkg::tile_field_width];
	assign feature_field =
		config_addr[tile_pkg::feature_field_lsb +: tile_pkg::feature_field_width];

	// tile field compared once.
	assign tile_match = (tile_field == tile_id);

	always_comb begin
		en_sb = 1'b0;
		en_cb0 = 1'b0;
		en_cb1 = 1'b0;
		en_clb = 1'b0;
		if (tile_match) begin
			case (feature_field)
				tile_pkg::config_sb: begin
					en_sb = 1'b1;
				end
				tile_pkg::config_cb0: begin
					en_cb0 = 1'b1;
				end
				tile_pkg::config_cb1: begin
					en_cb1 = 1'b1;
				end
				tile_pkg::config_clb: begin
					en_clb = 1'b1;
				end
				default: begin
					// unused feature code, no write.
				end
			endcase
		end
	end

endmodule

// File: rtl/connect_box.sv
module connect_box (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [7:0]             tracks,
	input  logic                   config_en,
	input  tile_pkg::config_word_u config_data,
	output logic                   block_out
);

	logic [tile_pkg::cb_sel_width-1:0] sel_q;

	// select register, track 0 after reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data.cb.sel;
		end
	end

	// 8-to-1 track mux.
	always_comb begin
		case (sel_q)
			3'd0: begin
				block_out = tracks[0];
			end
			3'd1: begin
				block_out = tracks[1];
			end
			3'd2: begin
				block_out = tracks[2];
			end
			3'd3: begin
				block_out = tracks[3];
			end
			3'd4: begin
				block_out = tracks[4];
			end
			3'd5: begin
				block_out = tracks[5];
			end
			3'd6: begin
				block_out = tracks[6];
			end
			default: begin
				block_out = tracks[7];
			end
		endcase
	end

endmodule

// File: rtl/pe_tile_bottom.sv
module pe_tile_bottom (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [tile_pkg::config_width-1:0] config_addr,
	input  logic [tile_pkg::config_width-1:0] config_data,
	input  logic [15:0]                       tile_id,
	input  logic in_wire_0_0, in_wire_0_1, in_wire_0_2, in_wire_0_3,
	input  logic in_wire_1_0, in_wire_1_1, in_wire_1_2, in_wire_1_3,
	input  logic in_wire_2_0, in_wire_2_1, in_wire_2_2, in_wire_2_3,
	input  logic in_wire_3_0, in_wire_3_1, in_wire_3_2, in_wire_3_3,
	output logic out_wire_0_0, out_wire_0_1, out_wire_0_2, out_wire_0_3,
	output logic out_wire_1_0,
	output logic out_wire_2_0, out_wire_2_1, out_wire_2_2, out_wire_2_3,
	output logic out_wire_3_0, out_wire_3_1, out_wire_3_2, out_wire_3_3
);

	tile_pkg::config_word_u config_word;
	logic [15:0] in_wires;
	logic [15:0] sb_out;
	logic en_sb, en_cb0, en_cb1, en_clb;
	logic op_0, op_1;
	logic pe_output;

	assign config_word = config_data;

	// pack tracks side-major, bit s * 4 + t.
	assign in_wires = {
		in_wire_3_3, in_wire_3_2, in_wire_3_1, in_wire_3_0,
		in_wire_2_3, in_wire_2_2, in_wire_2_1, in_wire_2_0,
		in_wire_1_3, in_wire_1_2, in_wire_1_1, in_wire_1_0,
		in_wire_0_3, in_wire_0_2, in_wire_0_1, in_wire_0_0
	};

	// side 1 is mostly internal on the bottom edge.
	assign {out_wire_0_3, out_wire_0_2, out_wire_0_1, out_wire_0_0} = sb_out[3:0];
	assign out_wire_1_0 = sb_out[4];
	assign {out_wire_2_3, out_wire_2_2, out_wire_2_1, out_wire_2_0} = sb_out[11:8];
	assign {out_wire_3_3, out_wire_3_2, out_wire_3_1, out_wire_3_0} = sb_out[15:12];

	config_decode decode (
		.config_addr (config_addr),
		.tile_id     (tile_id),
		.en_sb       (en_sb),
		.en_cb0      (en_cb0),
		.en_cb1      (en_cb1),
		.en_clb      (en_clb)
	);

	switch_box_bottom sb (
		.clk         (clk),
		.rst         (rst),
		.in_wires    (in_wires),
		.pe_output   (pe_output),
		.config_en   (en_sb),
		.config_data (config_word),
		.out_wires   (sb_out)
	);

	// tracks 0-3 from the side inputs, 4-7 from the same side's outputs.
	connect_box cb0 (
		.clk         (clk),
		.rst         (rst),
		.tracks      ({sb_out[3:0], in_wires[3:0]}),
		.config_en   (en_cb0),
		.config_data (config_word),
		.block_out   (op_0)
	);

	connect_box cb1 (
		.clk         (clk),
		.rst         (rst),
		.tracks      ({sb_out[7:4], in_wires[7:4]}),
		.config_en   (en_cb1),
		.config_data (config_word),
		.block_out   (op_1)
	);

	clb compute_block (
		.clk         (clk),
		.rst         (rst),
		.in0         (op_0),
		.in1         (op_1),
		.config_en   (en_clb),
		.config_data (config_word),
		.out         (pe_output)
	);

endmodule

// File: rtl/switch_box_bottom.sv
module switch_box_bottom (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [15:0]            in_wires,
	input  logic                   pe_output,
	input  logic                   config_en,
	input  tile_pkg::config_word_u config_data,
	output logic [15:0]            out_wires
);

	logic [tile_pkg::sb_outputs-1:0][tile_pkg::sb_sel_width-1:0] sel_q;

	// all sixteen selects written by one word.
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data.sb;
		end
	end

	// one mux per output, side s, track t.
	for (genvar s = 0; s < tile_pkg::num_sides; s++) begin : g_side
		for (genvar t = 0; t < tile_pkg::tracks_per_side; t++) begin : g_track
			logic [tile_pkg::sb_sel_width-1:0] sel;
			logic [3:0] choices;

			assign sel = sel_q[s * tile_pkg::tracks_per_side + t];

			// the other three sides in ascending order, same track.
			assign choices[0] =
				in_wires[((s == 0) ? 1 : 0) * tile_pkg::tracks_per_side + t];
			assign choices[1] =
				in_wires[((s <= 1) ? 2 : 1) * tile_pkg::tracks_per_side + t];
			assign choices[2] =
				in_wires[((s <= 2) ? 3 : 2) * tile_pkg::tracks_per_side + t];

			// last slot is the registered compute result.
			assign choices[tile_pkg::sel_pe] = pe_output;

			assign out_wires[s * tile_pkg::tracks_per_side + t] = choices[sel];
		end
	end

endmodule

// File: rtl/tile_pkg.sv
package tile_pkg;

	localparam int config_width = 32;

	// configuration address layout.
	localparam int tile_field_lsb = 0;
	localparam int tile_field_width = 16;
	localparam int feature_field_lsb = 16;
	localparam int feature_field_width = 16;

	// feature codes, upper half of the address.
	localparam logic [feature_field_width-1:0] config_sb = 16'd7;
	localparam logic [feature_field_width-1:0] config_cb0 = 16'd6;
	localparam logic [feature_field_width-1:0] config_cb1 = 16'd5;
	localparam logic [feature_field_width-1:0] config_clb = 16'd4;

	// track geometry.
	localparam int num_sides = 4;
	localparam int tracks_per_side = 4;
	localparam int sb_outputs = num_sides * tracks_per_side;

	// select and operation widths.
	localparam int sb_sel_width = 2;
	localparam int cb_sel_width = 3;
	localparam int op_width = 2;

	// switch box code for the compute block output.
	localparam logic [sb_sel_width-1:0] sel_pe = 2'd3;

	// compute block operations.
	localparam logic [op_width-1:0] op_and = 2'd0;
	localparam logic [op_width-1:0] op_or = 2'd1;
	localparam logic [op_width-1:0] op_xor = 2'd2;
	localparam logic [op_width-1:0] op_pass = 2'd3;

	// one configuration data word, read per feature.
	typedef union packed {
		// sixteen selects, side-major, output (s, t) at s * 4 + t.
		logic [sb_outputs-1:0][sb_sel_width-1:0] sb;

		// connect box track select.
		struct packed {
			logic [config_width-cb_sel_width-1:0] unused;
			logic [cb_sel_width-1:0] sel;
		} cb;

		// compute block operation.
		struct packed {
			logic [config_width-op_width-1:0] unused;
			logic [op_width-1:0] op;
		} clb;
	} config_word_u;

endpackage

// File: sources.f
rtl/tile_pkg.sv
rtl/config_decode.sv
rtl/connect_box.sv
rtl/switch_box_bottom.sv
rtl/clb.sv
rtl/pe_tile_bottom.sv
bench/tb_clock.sv
bench/tile_checker.sv
bench/tile_properties.sv
bench/tb_pe_tile_bottom.sv
